// ==== feLoadPkg.sv ====
// Shared widths, character codes and payload types; all ASCII codes are 7 bits, no parity
`default_nettype none

package feLoadPkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int wordBits          = 16;
  localparam int fieldBits         = 6;
  localparam int charBits          = 7;
  localparam int cramBits          = 86;
  localparam int cramAddrBits      = 11;
  localparam int dramAddrBits      = 8;
  localparam int cramWordsPerEntry = 6;
  localparam int dramWordsPerPair  = 3;

  ////////////////////
  // Character codes
  ////////////////////

  localparam logic [charBits-1:0] chComma          = 7'o054;
  localparam logic [charBits-1:0] chLineEnd        = 7'o012;
  // CR is whitespace, the line ends on LF only
  localparam logic [charBits-1:0] chCarriageReturn = 7'o015;
  localparam logic [charBits-1:0] chSpace          = 7'o040;
  // Valid ASCIIized field characters
  localparam logic [charBits-1:0] chFieldLow       = 7'o075;
  localparam logic [charBits-1:0] chFieldHigh      = 7'o174;
  // Record type letters
  localparam logic [charBits-1:0] chTypeCram       = 7'o103;
  localparam logic [charBits-1:0] chTypeDram       = 7'o104;
  localparam logic [charBits-1:0] chTypeZero       = 7'o132;
  localparam logic [charBits-1:0] chTypeComment    = 7'o073;

  typedef enum logic [2:0] {
    recNone,
    recCram,
    recDram,
    recZero,
    recComment,
    recBad
  } tRecType;

  ////////////////////
  // Payloads
  ////////////////////

  typedef logic [wordBits-1:0] tWord;

  // Bit 0 is the most significant, as in the KL10 prints
  typedef logic [0:cramBits-1] tCramWord;

  // Six load words, first word in the top bits
  typedef logic [cramWordsPerEntry*wordBits-1:0] tCramRaw;

  // Even, odd, common; even word in the top bits
  typedef logic [dramWordsPerPair*wordBits-1:0] tDramRaw;

  typedef struct packed {
    logic [2:0] aField;
    logic [2:0] bField;
    logic       parity;
    logic [3:0] jHigh;  // J1-J4, shared by the pair
    logic       j7;     // Shared, written from the odd word
    logic [2:0] jLow;   // J8-J10
  } tDramEntry;

  typedef struct packed {
    logic [cramAddrBits-1:0] address;
    tCramWord                data;
  } tCramWrite;

  typedef struct packed {
    logic [dramAddrBits-1:0] address;
    tDramEntry               entry;
  } tDramWrite;

  typedef struct packed {
    logic [15:0] lineCount;
    logic [7:0]  checksumErrors;
    logic [7:0]  formatErrors;
  } tLoaderStatus;

endpackage

`default_nettype wire

// ==== asciiWordDecoder.sv ====
// At most one character per cycle; characters outside 075-174 octal inside a field are dropped
`timescale 1ns/1ps
`default_nettype none

module asciiWordDecoder (
  input  wire logic                             clk,
  input  wire logic                             rstN,
  input  wire logic [feLoadPkg::charBits-1:0]   charIn,
  input  wire logic                             charValid,
  output logic      [feLoadPkg::charBits-1:0]   typeChar,
  output logic                                  typeValid,
  output feLoadPkg::tWord                       word,
  output logic                                  wordValid,
  output logic                                  lineEnd
);

  logic            atLineStart;
  feLoadPkg::tWord acc;
  logic            isBlank;
  logic            isSep;
  logic            isField;
  logic            isNewline;
  logic            takeType;
  logic            takeSep;

  // Character classes
  always_comb begin
    isNewline = charIn == feLoadPkg::chLineEnd;
    isBlank   = charIn == feLoadPkg::chSpace || charIn == feLoadPkg::chCarriageReturn;
    isSep     = charIn == feLoadPkg::chComma || isNewline;
    isField   = charIn >= feLoadPkg::chFieldLow && charIn <= feLoadPkg::chFieldHigh;
    // First printable character of a line is the record type
    // An empty line (bare newline) is skipped
    takeType  = charValid && atLineStart && !isBlank && !isNewline;
    takeSep   = charValid && !atLineStart && isSep;
  end

  // Control state and strobes
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      atLineStart <= 1'b1;
      typeValid   <= 1'b0;
      wordValid   <= 1'b0;
      lineEnd     <= 1'b0;
    end else begin
      typeValid <= takeType;
      wordValid <= takeSep;
      lineEnd   <= takeSep && isNewline;
      if (takeType) begin
        atLineStart <= 1'b0;
      end else if (takeSep && isNewline) begin
        atLineStart <= 1'b1;
      end
    end
  end

  // Field accumulator, 6 bits per character shifted in low
  always_ff @(posedge clk) begin
    if (takeType) begin
      typeChar <= charIn;
      acc      <= '0;
    end else if (takeSep) begin
      // Empty field reads as zero
      word <= acc;
      acc  <= '0;
    end else if (charValid && !atLineStart && isField) begin
      // Dropping bit 0100 leaves the low 6 bits
      acc <= {acc[feLoadPkg::wordBits-feLoadPkg::fieldBits-1:0],
              charIn[feLoadPkg::fieldBits-1:0]};
    end
  end

endmodule

`default_nettype wire

// ==== loadLineParser.sv ====
// Expects one type pulse per line before its words; a line with bad WC shape routes no data
`timescale 1ns/1ps
`default_nettype none

module loadLineParser (
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           enable,
  input  wire logic [feLoadPkg::charBits-1:0] typeChar,
  input  wire logic                           typeValid,
  input  wire feLoadPkg::tWord                word,
  input  wire logic                           wordValid,
  input  wire logic                           lineEnd,
  output logic                                cramWordValid,
  output logic                                dramWordValid,
  output feLoadPkg::tWord                     dataWord,
  output logic                                lineStart,
  output feLoadPkg::tWord                     startAddr,
  output logic                                lineDone,
  output logic                                checksumBad,
  output logic                                formatBad
);

  feLoadPkg::tRecType          recType;
  feLoadPkg::tWord             wc;
  feLoadPkg::tWord             sum;
  feLoadPkg::tWord             idx;
  feLoadPkg::tWord             effWc;
  feLoadPkg::tWord             newSum;
  logic [feLoadPkg::wordBits:0] wordsSeen;
  logic [feLoadPkg::wordBits:0] wordsNeeded;
  logic                        typeTake;
  logic                        wordTake;
  logic                        wcShapeOk;
  logic                        dataSlot;
  logic                        counted;

  function automatic feLoadPkg::tRecType decodeType(logic [feLoadPkg::charBits-1:0] ch);
    case (ch)
      feLoadPkg::chTypeCram:    return feLoadPkg::recCram;
      feLoadPkg::chTypeDram:    return feLoadPkg::recDram;
      feLoadPkg::chTypeZero:    return feLoadPkg::recZero;
      feLoadPkg::chTypeComment: return feLoadPkg::recComment;
      default:                  return feLoadPkg::recBad;
    endcase
  endfunction

  ////////////////////
  // Line bookkeeping
  ////////////////////

  always_comb begin
    typeTake = enable && typeValid;
    wordTake = enable && wordValid && recType != feLoadPkg::recNone;
    // WC is still on the input while the first word is taken
    effWc    = (idx == '0) ? word : wc;
    newSum   = sum + word;
    // Current word included
    wordsSeen   = {1'b0, idx} + 1'b1;
    wordsNeeded = {1'b0, effWc} + 2'd3;
    counted     = recType != feLoadPkg::recComment;
    case (recType)
      feLoadPkg::recCram: wcShapeOk = effWc % feLoadPkg::cramWordsPerEntry == 0;
      feLoadPkg::recDram: wcShapeOk = effWc % feLoadPkg::dramWordsPerPair == 0;
      feLoadPkg::recZero: wcShapeOk = 1'b1;
      default:            wcShapeOk = 1'b0;
    endcase
    // Words 2 .. WC+1 are data
    dataSlot = idx >= 2 && {1'b0, idx} < {1'b0, wc} + 2'd2 && wcShapeOk;
  end

  // Outcome is reported in the cycle of the last word
  always_comb begin
    lineDone    = wordTake && lineEnd;
    formatBad   = lineDone && counted && (!wcShapeOk || wordsSeen != wordsNeeded);
    // Sum only judged on a well-formed line
    checksumBad = lineDone && counted && wcShapeOk && wordsSeen == wordsNeeded &&
                  newSum != '0;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      recType       <= feLoadPkg::recNone;
      idx           <= '0;
      wc            <= '0;
      sum           <= '0;
      cramWordValid <= 1'b0;
      dramWordValid <= 1'b0;
      lineStart     <= 1'b0;
    end else begin
      cramWordValid <= 1'b0;
      dramWordValid <= 1'b0;
      lineStart     <= 1'b0;
      if (typeTake) begin
        recType <= decodeType(typeChar);
        idx     <= '0;
        sum     <= '0;
      end else if (wordTake) begin
        sum <= newSum;
        // Saturate so a runaway line stays flagged as too long
        if (idx != '1) begin
          idx <= idx + 1'b1;
        end
        if (idx == '0) begin
          wc <= word;
        end
        if (idx == 1 && counted) begin
          lineStart <= 1'b1;
        end
        // Data goes out before the checksum is known
        if (dataSlot) begin
          cramWordValid <= recType == feLoadPkg::recCram;
          dramWordValid <= recType == feLoadPkg::recDram;
        end
        if (lineEnd) begin
          recType <= feLoadPkg::recNone;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wordTake) begin
      dataWord <= word;
      if (idx == 1) begin
        startAddr <= word;
      end
    end
  end

  // One outcome per line
  assert property (@(posedge clk) disable iff (!rstN) !(checksumBad && formatBad))
    else $error("line reported with both checksum and format faults");

endmodule

`default_nettype wire

// ==== wordGatherer.sv ====
// Payload width must be a multiple of 16; a line must not end in the middle of a payload
`timescale 1ns/1ps
`default_nettype none

module wordGatherer #(
  parameter type tPayload = feLoadPkg::tCramRaw,
  parameter int  addrStep = 1,
  parameter int  addrBits = feLoadPkg::cramAddrBits
) (
  input  wire logic            clk,
  input  wire logic            rstN,
  input  wire logic            lineStart,
  input  wire feLoadPkg::tWord startAddr,
  input  wire feLoadPkg::tWord wordIn,
  input  wire logic            wordValid,
  output tPayload              payload,
  output logic [addrBits-1:0]  payloadAddr,
  output logic                 payloadValid
);

  localparam int payloadBits = $bits(tPayload);
  localparam int wordsPer    = payloadBits / feLoadPkg::wordBits;
  localparam int cntBits     = $clog2(wordsPer);

  logic [payloadBits-1:0] shiftReg;
  logic [cntBits-1:0]     count;
  logic [addrBits-1:0]    addr;
  logic                   lastWord;

  assign lastWord = wordValid && count == cntBits'(wordsPer - 1);

  // Held until the next word, so valid for the whole pulse
  assign payload = tPayload'(shiftReg);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      count        <= '0;
      addr         <= '0;
      payloadAddr  <= '0;
      payloadValid <= 1'b0;
    end else begin
      payloadValid <= lastWord;
      if (lineStart) begin
        count <= '0;
        addr  <= startAddr[addrBits-1:0];
      end else if (lastWord) begin
        count       <= '0;
        payloadAddr <= addr;
        addr        <= addr + addrBits'(addrStep);
      end else if (wordValid) begin
        count <= count + 1'b1;
      end
    end
  end

  // First word ends up in the top bits
  always_ff @(posedge clk) begin
    if (wordValid) begin
      shiftReg <= {shiftReg[payloadBits-feLoadPkg::wordBits-1:0], wordIn};
    end
  end

  // A new line starts only on a payload boundary
  assert property (@(posedge clk) disable iff (!rstN) lineStart |-> count == '0)
    else $error("lineStart in the middle of a payload");

endmodule

`default_nettype wire

// ==== dramPairSplitter.sv ====
// Needs at least one idle cycle between pairs; the odd write always follows the even write
`timescale 1ns/1ps
`default_nettype none

module dramPairSplitter (
  input  wire logic                               clk,
  input  wire logic                               rstN,
  input  wire feLoadPkg::tDramRaw                 pairIn,
  input  wire logic [feLoadPkg::dramAddrBits-1:0] pairAddr,
  input  wire logic                               pairValid,
  output logic                                    dramWr,
  output feLoadPkg::tDramWrite                    dramWrite
);

  feLoadPkg::tWord      evenWord;
  feLoadPkg::tWord      oddWord;
  feLoadPkg::tWord      commonWord;
  feLoadPkg::tDramWrite oddWrite;
  logic                 oddPending;

  // WDRAM word layout
  function automatic feLoadPkg::tDramEntry mapEntry(feLoadPkg::tWord w,
                                                    feLoadPkg::tWord common,
                                                    logic            j7);
    feLoadPkg::tDramEntry e;
    e.aField = w[13:11];
    e.bField = w[10:8];
    e.parity = w[5];
    e.jHigh  = common[3:0];
    e.j7     = j7;
    e.jLow   = w[2:0];
    return e;
  endfunction

  assign evenWord   = pairIn[47:32];
  assign oddWord    = pairIn[31:16];
  assign commonWord = pairIn[15:0];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dramWr     <= 1'b0;
      oddPending <= 1'b0;
    end else begin
      dramWr     <= pairValid || oddPending;
      oddPending <= pairValid;
    end
  end

  always_ff @(posedge clk) begin
    if (pairValid) begin
      // Even entry now, odd entry one cycle later
      // J7 comes from the odd word for both
      dramWrite.address <= pairAddr;
      dramWrite.entry   <= mapEntry(evenWord, commonWord, oddWord[3]);
      oddWrite.address  <= pairAddr + 1'b1;
      oddWrite.entry    <= mapEntry(oddWord, commonWord, oddWord[3]);
    end else if (oddPending) begin
      dramWrite <= oddWrite;
    end
  end

  // Gatherer spacing keeps pairs apart
  assert property (@(posedge clk) disable iff (!rstN) pairValid |-> !oddPending)
    else $error("new DRAM pair while odd write pending");

endmodule

`default_nettype wire

// ==== loaderStatusRegs.sv ====
// Counters saturate at full scale; statusClear wins over a line finishing in the same cycle
`timescale 1ns/1ps
`default_nettype none

module loaderStatusRegs (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire logic              loadEnable,
  input  wire logic              statusClear,
  input  wire logic              lineDone,
  input  wire logic              checksumBad,
  input  wire logic              formatBad,
  output logic                   parserEnable,
  output feLoadPkg::tLoaderStatus status
);

  ////////////////////
  // Enable and counters
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      parserEnable <= 1'b0;
      status       <= '0;
    end else begin
      // One cycle late, lines up with decoder output
      parserEnable <= loadEnable;
      if (statusClear) begin
        status <= '0;
      end else if (lineDone) begin
        if (status.lineCount != '1) begin
          status.lineCount <= status.lineCount + 1'b1;
        end
        // Parser raises at most one of these
        if (checksumBad && status.checksumErrors != '1) begin
          status.checksumErrors <= status.checksumErrors + 1'b1;
        end
        if (formatBad && status.formatErrors != '1) begin
          status.formatErrors <= status.formatErrors + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== microcodeLoader.sv ====
// No back-pressure: one character per cycle at most, writes are pulses with no acknowledge
`timescale 1ns/1ps
`default_nettype none

module microcodeLoader (
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic [feLoadPkg::charBits-1:0] charIn,
  input  wire logic                           charValid,
  input  wire logic                           loadEnable,
  input  wire logic                           statusClear,
  output logic                                cramWr,
  output feLoadPkg::tCramWrite                cramWrite,
  output logic                                dramWr,
  output feLoadPkg::tDramWrite                dramWrite,
  output feLoadPkg::tLoaderStatus             status
);

  logic [feLoadPkg::charBits-1:0]     typeChar;
  logic                               typeValid;
  feLoadPkg::tWord                    word;
  logic                               wordValid;
  logic                               lineEnd;
  logic                               parserEnable;
  logic                               cramWordValid;
  logic                               dramWordValid;
  feLoadPkg::tWord                    dataWord;
  logic                               lineStart;
  feLoadPkg::tWord                    startAddr;
  logic                               lineDone;
  logic                               checksumBad;
  logic                               formatBad;
  feLoadPkg::tCramRaw                 cramRaw;
  logic [feLoadPkg::cramAddrBits-1:0] cramAddr;
  feLoadPkg::tDramRaw                 dramRaw;
  logic [feLoadPkg::dramAddrBits-1:0] dramAddr;
  logic                               dramPairValid;

  asciiWordDecoder i_asciiWordDecoder (
    .clk, .rstN, .charIn, .charValid,
    .typeChar, .typeValid, .word, .wordValid, .lineEnd
  );

  loadLineParser i_loadLineParser (
    .clk, .rstN, .enable(parserEnable),
    .typeChar, .typeValid, .word, .wordValid, .lineEnd,
    .cramWordValid, .dramWordValid, .dataWord, .lineStart, .startAddr,
    .lineDone, .checksumBad, .formatBad
  );

  loaderStatusRegs i_loaderStatusRegs (
    .clk, .rstN, .loadEnable, .statusClear,
    .lineDone, .checksumBad, .formatBad, .parserEnable, .status
  );

  // CRAM path, one entry per six words
  wordGatherer #(
    .tPayload(feLoadPkg::tCramRaw),
    .addrStep(1),
    .addrBits(feLoadPkg::cramAddrBits)
  ) i_cramGatherer (
    .clk, .rstN, .lineStart, .startAddr,
    .wordIn(dataWord), .wordValid(cramWordValid),
    .payload(cramRaw), .payloadAddr(cramAddr), .payloadValid(cramWr)
  );

  // DRAM path, one even/odd pair per three words
  wordGatherer #(
    .tPayload(feLoadPkg::tDramRaw),
    .addrStep(2),
    .addrBits(feLoadPkg::dramAddrBits)
  ) i_dramGatherer (
    .clk, .rstN, .lineStart, .startAddr,
    .wordIn(dataWord), .wordValid(dramWordValid),
    .payload(dramRaw), .payloadAddr(dramAddr), .payloadValid(dramPairValid)
  );

  dramPairSplitter i_dramPairSplitter (
    .clk, .rstN, .pairIn(dramRaw), .pairAddr(dramAddr), .pairValid(dramPairValid),
    .dramWr, .dramWrite
  );

  // WCRAM order: 64-79, 48-63, 32-47, 16-31, 0-15, then 80-85
  always_comb begin
    cramWrite.address      = cramAddr;
    cramWrite.data[64:79]  = cramRaw[95:80];
    cramWrite.data[48:63]  = cramRaw[79:64];
    cramWrite.data[32:47]  = cramRaw[63:48];
    cramWrite.data[16:31]  = cramRaw[47:32];
    cramWrite.data[0:15]   = cramRaw[31:16];
    // CALL and DISP bits, sixth word low 6 bits
    cramWrite.data[80:85]  = cramRaw[5:0];
  end

endmodule

`default_nettype wire

// ==== loadFileGen.svh ====
// Included in the testbench module body; needs sendChar and cycleLimit declared before it
`ifndef LOADFILEGEN_SVH
`define LOADFILEGEN_SVH

////////////////////
// Reference model
////////////////////

feLoadPkg::tCramWrite    expCram[$];
feLoadPkg::tDramWrite    expDram[$];
feLoadPkg::tLoaderStatus expStatus;
// Low while loadEnable is low, nothing is expected then
logic                    modelEnable;

// Octal 75-77 stand for themselves, all others get bit 0100
function automatic logic [6:0] asciiize(input logic [5:0] v);
  return (v >= 6'o75) ? {1'b0, v} : {1'b1, v};
endfunction

function automatic feLoadPkg::tDramEntry expectEntry(input feLoadPkg::tWord w,
                                                     input feLoadPkg::tWord common,
                                                     input feLoadPkg::tWord odd);
  feLoadPkg::tDramEntry e;
  e.aField = w[13:11];
  e.bField = w[10:8];
  e.parity = w[5];
  e.jHigh  = common[3:0];
  // J7 of both entries from the odd word
  e.j7     = odd[3];
  e.jLow   = w[2:0];
  return e;
endfunction

// Counters and writes for one line, by the load-file rules
task automatic modelLine(input logic [6:0] typeCh, input feLoadPkg::tWord w[$]);
  feLoadPkg::tWord      sum;
  feLoadPkg::tCramWrite cw;
  feLoadPkg::tDramWrite dw;
  int                   wc;
  logic                 isC;
  logic                 isD;
  logic                 fmtBad;
  if (!modelEnable) return;
  expStatus.lineCount = expStatus.lineCount + 1'b1;
  // Comment lines only count
  if (typeCh == feLoadPkg::chTypeComment) return;
  isC    = typeCh == feLoadPkg::chTypeCram;
  isD    = typeCh == feLoadPkg::chTypeDram;
  wc     = (w.size() > 0) ? int'(w[0]) : 0;
  sum    = '0;
  foreach (w[i]) sum += w[i];
  fmtBad = !(isC || isD || typeCh == feLoadPkg::chTypeZero) || w.size() != wc + 3 ||
           (isC && wc % 6 != 0) || (isD && wc % 3 != 0);
  if (fmtBad) begin
    expStatus.formatErrors = expStatus.formatErrors + 1'b1;
    return;
  end
  if (sum != '0) expStatus.checksumErrors = expStatus.checksumErrors + 1'b1;
  // Six words per CRAM entry
  for (int e = 0; isC && e < wc / 6; e++) begin
    cw.address      = 11'(int'(w[1]) + e);
    cw.data[64:79]  = w[2 + 6*e];
    cw.data[48:63]  = w[3 + 6*e];
    cw.data[32:47]  = w[4 + 6*e];
    cw.data[16:31]  = w[5 + 6*e];
    cw.data[0:15]   = w[6 + 6*e];
    cw.data[80:85]  = w[7 + 6*e][5:0];
    expCram.push_back(cw);
  end
  // Even, odd, common per DRAM pair
  for (int p = 0; isD && p < wc / 3; p++) begin
    dw.address = 8'(int'(w[1]) + 2*p);
    dw.entry   = expectEntry(w[2 + 3*p], w[4 + 3*p], w[3 + 3*p]);
    expDram.push_back(dw);
    dw.address = 8'(int'(w[1]) + 2*p + 1);
    dw.entry   = expectEntry(w[3 + 3*p], w[4 + 3*p], w[3 + 3*p]);
    expDram.push_back(dw);
  end
endtask

////////////////////
// Line generator
////////////////////

// Leading zero fields suppressed, zero is an empty field
task automatic sendWord(input feLoadPkg::tWord w);
  if (w >= 16'o10000) sendChar(asciiize({2'b00, w[15:12]}));
  if (w >= 16'o100) sendChar(asciiize(w[11:6]));
  if (w != '0) sendChar(asciiize(w[5:0]));
endtask

// Model first, writes start before the line ends
task automatic emitLine(input logic [6:0] typeCh, input feLoadPkg::tWord w[$]);
  modelLine(typeCh, w);
  sendChar(typeCh);
  sendChar(feLoadPkg::chSpace);
  foreach (w[i]) begin
    if (i != 0) sendChar(feLoadPkg::chComma);
    sendWord(w[i]);
  end
  if ($urandom_range(1, 0) == 1) sendChar(feLoadPkg::chCarriageReturn);
  sendChar(feLoadPkg::chLineEnd);
endtask

// WC, random ADR, WC random data words, then the checksum
task automatic genRecord(input logic [6:0] typeCh, input int wc, input int adrMax,
                         input bit badSum);
  feLoadPkg::tWord w[$];
  feLoadPkg::tWord sum;
  w.push_back(feLoadPkg::tWord'(wc));
  w.push_back(feLoadPkg::tWord'($urandom_range(adrMax, 0)));
  repeat (wc) w.push_back(feLoadPkg::tWord'($urandom));
  sum = '0;
  foreach (w[i]) sum += w[i];
  // Off by one when a bad checksum is wanted
  w.push_back(feLoadPkg::tWord'(-sum) + (badSum ? 16'd1 : 16'd0));
  emitLine(typeCh, w);
endtask

// C line that stops after ADR
task automatic genShortLine();
  feLoadPkg::tWord w[$];
  w.push_back(16'd6);
  w.push_back(feLoadPkg::tWord'($urandom_range(2047, 0)));
  emitLine(feLoadPkg::chTypeCram, w);
endtask

// Semicolon, random letters and spaces
task automatic genComment();
  feLoadPkg::tWord none[$];
  modelLine(feLoadPkg::chTypeComment, none);
  sendChar(feLoadPkg::chTypeComment);
  repeat ($urandom_range(8, 0)) begin
    if ($urandom_range(3, 0) == 0) sendChar(feLoadPkg::chSpace);
    else sendChar(7'o101 + 7'($urandom_range(25, 0)));
  end
  sendChar(feLoadPkg::chLineEnd);
endtask

// The ",," end line, a comma is no known type
task automatic genEndLine();
  feLoadPkg::tWord none[$];
  modelLine(feLoadPkg::chComma, none);
  sendChar(feLoadPkg::chComma);
  sendChar(feLoadPkg::chComma);
  sendChar(feLoadPkg::chLineEnd);
endtask

`endif

// ==== tbMicrocodeLoader.sv ====
// Fixed seed 98533; the cycle limit grows with every character and idle gap that is sent
`timescale 1ns/1ps
`default_nettype none

module tbMicrocodeLoader;

  logic                           clk;
  logic                           rstN;
  logic [feLoadPkg::charBits-1:0] charIn;
  logic                           charValid;
  logic                           loadEnable;
  logic                           statusClear;
  logic                           cramWr;
  feLoadPkg::tCramWrite           cramWrite;
  logic                           dramWr;
  feLoadPkg::tDramWrite           dramWrite;
  feLoadPkg::tLoaderStatus        status;
  int                             cramErrors;
  int                             dramErrors;
  int                             statusErrors;
  int                             cycleCount;
  int                             cycleLimit;

  microcodeLoader i_microcodeLoader (
    .clk, .rstN, .charIn, .charValid, .loadEnable, .statusClear,
    .cramWr, .cramWrite, .dramWr, .dramWrite, .status
  );

  always #50 clk = ~clk;

  // One character on a falling edge, then 0 to 3 idle cycles
  task automatic sendChar(input logic [feLoadPkg::charBits-1:0] c);
    int gap;
    gap = $urandom_range(3, 0);
    cycleLimit += 1 + gap;
    @(negedge clk);
    charIn    = c;
    charValid = 1'b1;
    repeat (gap) begin
      @(negedge clk);
      charValid = 1'b0;
    end
  endtask

  `include "loadFileGen.svh"

  ////////////////////
  // Checks
  ////////////////////

  task automatic checkCram(input feLoadPkg::tCramWrite got);
    feLoadPkg::tCramWrite exp;
    if (expCram.size() == 0) begin
      $display("Unexpected CRAM write at %0t to address %0h", $time, got.address);
      cramErrors++;
    end else begin
      exp = expCram.pop_front();
      if (got !== exp) begin
        $display("ERR %0t cramWrite expected %h got %h", $time, exp, got);
        cramErrors++;
      end
    end
  endtask

  task automatic checkDram(input feLoadPkg::tDramWrite got);
    feLoadPkg::tDramWrite exp;
    if (expDram.size() == 0) begin
      $display("Unexpected DRAM write at %0t to address %0h", $time, got.address);
      dramErrors++;
    end else begin
      exp = expDram.pop_front();
      if (got !== exp) begin
        $display("ERR %0t dramWrite expected %h got %h", $time, exp, got);
        dramErrors++;
      end
    end
  endtask

  task automatic checkStatus(input feLoadPkg::tLoaderStatus got);
    if (got !== expStatus) begin
      $display("ERR %0t status expected %h got %h", $time, expStatus, got);
      statusErrors++;
    end
  endtask

  task automatic reportLeftovers();
    if (expCram.size() != 0) begin
      $display("%0d expected CRAM writes never appeared", expCram.size());
      cramErrors += expCram.size();
    end
    if (expDram.size() != 0) begin
      $display("%0d expected DRAM writes never appeared", expDram.size());
      dramErrors += expDram.size();
    end
  endtask

  // Until all expected writes are out and the last line is counted
  task automatic waitDrain();
    cycleLimit += 20;
    @(negedge clk);
    charValid = 1'b0;
    while (expCram.size() != 0 || expDram.size() != 0 ||
           status.lineCount !== expStatus.lineCount) begin
      @(negedge clk);
    end
  endtask

  // Write ports are registered, look at them mid-cycle
  always @(negedge clk) begin
    if (rstN) begin
      if (cramWr) checkCram(cramWrite);
      if (dramWr) checkDram(dramWrite);
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      reportLeftovers();
      $display("Timeout after %0d cycles waiting for the loader", cycleCount);
      $display("Errors: cram %0d, dram %0d, status %0d", cramErrors, dramErrors, statusErrors);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    void'($urandom(98533));
    clk          = 1'b0;
    rstN         = 1'b0;
    charIn       = '0;
    charValid    = 1'b0;
    loadEnable   = 1'b1;
    statusClear  = 1'b0;
    modelEnable  = 1'b1;
    expStatus    = '0;
    cramErrors   = 0;
    dramErrors   = 0;
    statusErrors = 0;
    cycleCount   = 0;
    cycleLimit   = 8 + 200;
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    checkStatus(status);

    // Good records among comments
    repeat (12) begin
      case ($urandom_range(4, 0))
        0, 1:    genRecord(feLoadPkg::chTypeCram, 6 * $urandom_range(3, 1), 2047, 1'b0);
        2, 3:    genRecord(feLoadPkg::chTypeDram, 3 * $urandom_range(3, 1), 255, 1'b0);
        default: genComment();
      endcase
    end
    genRecord(feLoadPkg::chTypeZero, $urandom_range(4, 1), 2047, 1'b0);
    genEndLine();
    waitDrain();
    checkStatus(status);

    // Bad checksum, then the format faults
    genRecord(feLoadPkg::chTypeCram, 6, 2047, 1'b1);
    genRecord(7'o130, 3, 2047, 1'b0);
    genShortLine();
    genRecord(feLoadPkg::chTypeCram, 6 + $urandom_range(5, 1), 2047, 1'b0);
    waitDrain();
    checkStatus(status);

    // Loader disabled, nothing may change
    loadEnable  = 1'b0;
    modelEnable = 1'b0;
    genRecord(feLoadPkg::chTypeCram, 6, 2047, 1'b0);
    genRecord(feLoadPkg::chTypeDram, 3, 255, 1'b0);
    genComment();
    waitDrain();
    // Nothing to wait for, let the 5-cycle write latency pass
    cycleLimit += 5;
    repeat (5) @(negedge clk);
    loadEnable  = 1'b1;
    modelEnable = 1'b1;
    checkStatus(status);

    // Clear, then counting resumes
    cycleLimit += 2;
    @(negedge clk);
    statusClear = 1'b1;
    @(negedge clk);
    statusClear = 1'b0;
    expStatus   = '0;
    checkStatus(status);
    genRecord(feLoadPkg::chTypeDram, 6, 255, 1'b0);
    genRecord(feLoadPkg::chTypeCram, 12, 2047, 1'b1);
    genComment();
    waitDrain();
    checkStatus(status);

    // Longest write latency is 5 cycles, catch strays
    cycleLimit += 8;
    repeat (8) @(negedge clk);
    reportLeftovers();
    $display("Errors: cram %0d, dram %0d, status %0d", cramErrors, dramErrors, statusErrors);
    if (cramErrors + dramErrors + statusErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
feLoadPkg.sv
asciiWordDecoder.sv
loadLineParser.sv
wordGatherer.sv
dramPairSplitter.sv
loaderStatusRegs.sv
microcodeLoader.sv
tbMicrocodeLoader.sv
